// ==== hw/video_macros.svh ====
// frame geometry, blanking and width constants for the video test-pattern path

`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// active picture, kept small so a frame is only a few dozen cycles
`define VID_WIDTH       8
`define VID_HEIGHT      4

// idle cycles at the end of each line and idle lines at the end of each frame
`define VID_H_BLANK     2
`define VID_V_BLANK     1

// one lane per component
`define VID_COMPONENTS  3
`define VID_DATA_BITS   8

// x, y and frame counters
`define VID_COORD_BITS  16

`endif

// ==== hw/video_pkg.sv ====
// stream types shared by the pipeline stages
// component, pixel, sideband, pipeline beat and counter types

`include "video_macros.svh"

package video_pkg;

    // a single colour component
    typedef logic [`VID_DATA_BITS-1:0] comp_t;

    // component 0 sits in the low bits of tdata
    typedef comp_t [`VID_COMPONENTS-1:0] pixel_t;

    // framing flags that travel next to the pixel
    typedef struct packed {
        logic sof;
        logic eol;
    } side_t;

    // one pipeline slot, valid low marks a blanking position
    typedef struct packed {
        logic   valid;
        side_t  side;
        pixel_t pixel;
    } beat_t;

    // raster and frame counter value
    typedef logic [`VID_COORD_BITS-1:0] coord_t;

endpackage

// ==== hw/lane_cfg_pkg.sv ====
// per-lane gain and offset configuration types

package lane_cfg_pkg;

    // unsigned fixed point with four fraction bits, 16 is a gain of 1.0
    typedef logic [7:0] gain_t;

    // unsigned offset added after the gain
    typedef logic [7:0] offset_t;

    // settings for one component lane
    typedef struct packed {
        gain_t   gain;
        offset_t offset;
    } lane_cfg_t;

endpackage

// ==== hw/frame_source.sv ====
// test-pattern raster source with horizontal and vertical blanking
// frame start and busy control, registered beat output

`timescale 1ns/1ps

`include "video_macros.svh"

module frame_source (
    input  logic               m_axi4s,
    input  logic               rst_n,
    input  logic               enable,
    input  logic               stall,
    output logic               busy,
    output video_pkg::coord_t  frame,
    output video_pkg::beat_t   beat
);

    localparam int TOTAL_H = `VID_WIDTH + `VID_H_BLANK;
    localparam int TOTAL_V = `VID_HEIGHT + `VID_V_BLANK;

    video_pkg::coord_t  x;
    video_pkg::coord_t  y;
    logic               line_end;
    logic               frame_end;
    logic               active;

    logic               beat_valid;
    video_pkg::side_t   beat_side;
    video_pkg::pixel_t  beat_pixel;

    assign line_end  = (x == video_pkg::coord_t'(TOTAL_H - 1));
    assign frame_end = line_end && (y == video_pkg::coord_t'(TOTAL_V - 1));
    assign active    = (x < video_pkg::coord_t'(`VID_WIDTH)) &&
                       (y < video_pkg::coord_t'(`VID_HEIGHT));

    // raster walk, everything holds while the output is stalled
    always_ff @(posedge m_axi4s) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            x          <= '0;
            y          <= '0;
            frame      <= '0;
            beat_valid <= 1'b0;
        end else if (!stall) begin
            beat_valid <= busy && active;
            if (!busy) begin
                if (enable) begin
                    busy <= 1'b1;
                    x    <= '0;
                    y    <= '0;
                end
            end else if (line_end) begin
                x <= '0;
                if (frame_end) begin
                    // the last blanking cycle closes the frame
                    y     <= '0;
                    busy  <= 1'b0;
                    frame <= frame + 1'b1;
                end else begin
                    y <= y + 1'b1;
                end
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // pattern payload, only meaningful where beat_valid is high
    always_ff @(posedge m_axi4s) begin
        if (!stall) begin
            beat_side.sof <= (x == '0) && (y == '0);
            beat_side.eol <= (x == video_pkg::coord_t'(`VID_WIDTH - 1)) &&
                             (y < video_pkg::coord_t'(`VID_HEIGHT));
            beat_pixel[0] <= video_pkg::comp_t'(x);
            beat_pixel[1] <= video_pkg::comp_t'(y);
            beat_pixel[2] <= video_pkg::comp_t'(frame);
        end
    end

    assign beat = '{valid: beat_valid, side: beat_side, pixel: beat_pixel};

endmodule

// ==== hw/component_lane.sv ====
// single-component gain and offset stage with saturation
// result register holds while the pipeline is stalled

`timescale 1ns/1ps

module component_lane (
    input  logic                    m_axi4s,
    input  logic                    rst_n,
    input  logic                    stall,
    input  lane_cfg_pkg::lane_cfg_t cfg,
    input  video_pkg::comp_t        in_comp,
    input  logic                    in_valid,
    output video_pkg::comp_t        out_comp,
    output logic                    out_valid
);

    localparam int DATA_BITS = $bits(video_pkg::comp_t);
    localparam int GAIN_BITS = $bits(lane_cfg_pkg::gain_t);
    localparam int FRAC_BITS = 4;
    localparam int PROD_BITS = DATA_BITS + GAIN_BITS;
    // one extra bit catches the carry of the offset add
    localparam int SUM_BITS  = PROD_BITS - FRAC_BITS + 1;

    logic [PROD_BITS-1:0] prod;
    logic [SUM_BITS-1:0]  sum;
    video_pkg::comp_t     sat;

    assign prod = PROD_BITS'(cfg.gain) * PROD_BITS'(in_comp);
    assign sum  = SUM_BITS'(prod >> FRAC_BITS) + SUM_BITS'(cfg.offset);

    // clamp to full scale on overflow
    assign sat = (sum > SUM_BITS'({DATA_BITS{1'b1}})) ? '1 : DATA_BITS'(sum);

    always_ff @(posedge m_axi4s) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (!stall) begin
            out_comp <= sat;
        end
    end

endmodule

// ==== hw/pixel_merge.sv ====
// joins the lane results with their delayed sideband into the output stream
// owns the AXI4-Stream output register and generates the pipeline stall

`timescale 1ns/1ps

module pixel_merge (
    input  logic               m_axi4s,
    input  logic               rst_n,
    input  video_pkg::pixel_t  lane_comp,
    input  logic               lane_valid,
    input  video_pkg::side_t   side,
    input  logic               tready,
    output logic               stall,
    output logic               tvalid,
    output video_pkg::pixel_t  tdata,
    output logic               tuser,
    output logic               tlast
);

    // sideband leaves the source one cycle ahead of the lane results
    video_pkg::side_t side_d;

    logic             out_valid;
    video_pkg::side_t out_side;
    video_pkg::pixel_t out_pixel;

    // a full output register that is not being taken freezes the whole pipe
    assign stall = out_valid && !tready;

    always_ff @(posedge m_axi4s) begin
        if (!stall) begin
            side_d <= side;
        end
    end

    always_ff @(posedge m_axi4s) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= lane_valid;
        end
    end

    // loaded whenever the register is empty or drains on this edge
    always_ff @(posedge m_axi4s) begin
        if (!stall) begin
            out_side  <= side_d;
            out_pixel <= lane_comp;
        end
    end

    assign tvalid = out_valid;
    assign tdata  = out_pixel;
    assign tuser  = out_side.sof;
    assign tlast  = out_side.eol;

endmodule

// ==== hw/video_pipe_top.sv ====
// top level of the test-pattern path
// source, one generated lane per component, and the output merger

`timescale 1ns/1ps

`include "video_macros.svh"

module video_pipe_top (
    input  logic                                          m_axi4s,
    input  logic                                          rst_n,
    input  logic                                          enable,
    input  logic                                          tready,
    input  lane_cfg_pkg::lane_cfg_t [`VID_COMPONENTS-1:0] lane_cfg,
    output logic                                          busy,
    output video_pkg::coord_t                             frame,
    output logic                                          tvalid,
    output video_pkg::pixel_t                             tdata,
    output logic                                          tuser,
    output logic                                          tlast
);

    logic                       stall;
    video_pkg::beat_t           src_beat;
    video_pkg::pixel_t          lane_comp;
    logic [`VID_COMPONENTS-1:0] lane_valid;

    frame_source i_frame_source (
        .m_axi4s (m_axi4s),
        .rst_n   (rst_n),
        .enable  (enable),
        .stall   (stall),
        .busy    (busy),
        .frame   (frame),
        .beat    (src_beat)
    );

    for (genvar i = 0; i < `VID_COMPONENTS; i++) begin : g_lane
        component_lane i_component_lane (
            .m_axi4s   (m_axi4s),
            .rst_n     (rst_n),
            .stall     (stall),
            .cfg       (lane_cfg[i]),
            .in_comp   (src_beat.pixel[i]),
            .in_valid  (src_beat.valid),
            .out_comp  (lane_comp[i]),
            .out_valid (lane_valid[i])
        );
    end

    // all lanes share stall and valid, so lane 0 speaks for them
    pixel_merge i_pixel_merge (
        .m_axi4s    (m_axi4s),
        .rst_n      (rst_n),
        .lane_comp  (lane_comp),
        .lane_valid (lane_valid[0]),
        .side       (src_beat.side),
        .tready     (tready),
        .stall      (stall),
        .tvalid     (tvalid),
        .tdata      (tdata),
        .tuser      (tuser),
        .tlast      (tlast)
    );

endmodule

// ==== verif/video_pipe_assertions.sv ====
// stream protocol assertions, bound to the video pipe top level
// reset state, hold under back-pressure and start-of-frame placement

`timescale 1ns/1ps

module video_pipe_assertions (
    input logic              m_axi4s,
    input logic              rst_n,
    input logic              busy,
    input logic              tvalid,
    input logic              tready,
    input video_pkg::pixel_t tdata,
    input logic              tuser,
    input logic              tlast
);

    logic busy_d;
    // high where a start of frame may legally appear on the next beat
    logic sof_allowed;

    always_ff @(posedge m_axi4s) begin
        if (!rst_n) begin
            busy_d      <= 1'b0;
            sof_allowed <= 1'b0;
        end else begin
            busy_d <= busy;
            if (busy && !busy_d) begin
                sof_allowed <= 1'b1;
            end else if (tvalid && tready) begin
                sof_allowed <= tlast;
            end
        end
    end

    a_reset_idle: assert property (@(posedge m_axi4s) !rst_n |=> !tvalid && !busy)
        else $error("tvalid or busy high right after reset");

    a_hold_stalled: assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tuser) && $stable(tlast))
        else $error("output beat changed while waiting for tready");

    a_sof_place: assert property (@(posedge m_axi4s) disable iff (!rst_n)
        tvalid && tuser |-> sof_allowed)
        else $error("tuser on a beat that does not start a frame");

endmodule

bind video_pipe_top video_pipe_assertions i_assertions (.*);

// ==== verif/video_pipe_tb.sv ====
// testbench for the video test-pattern path
// file-driven lane settings, throttled tready and a pixel reference model

`timescale 1ns/1ps

`include "video_macros.svh"

module video_pipe_tb;

    localparam int BEATS_PER_FRAME = `VID_WIDTH * `VID_HEIGHT;
    localparam int WAIT_LIMIT      = 20000;

    logic                                          m_axi4s;
    logic                                          rst_n;
    logic                                          enable;
    logic                                          tready = 1'b1;
    lane_cfg_pkg::lane_cfg_t [`VID_COMPONENTS-1:0] lane_cfg;
    logic                                          busy;
    video_pkg::coord_t                             frame;
    logic                                          tvalid;
    video_pkg::pixel_t                             tdata;
    logic                                          tuser;
    logic                                          tlast;

    video_pkg::beat_t  expected_q[$];
    video_pkg::coord_t rx_count;
    video_pkg::coord_t rx_target;
    video_pkg::coord_t frames_run;
    logic [31:0]       lcg_state;
    int unsigned       busy_rate;
    int                mismatches;
    int                timeouts;
    int                other_errors;
    logic              abort;

    video_pipe_top i_dut (.*);

    initial begin
        m_axi4s = 1'b0;
        forever #20 m_axi4s = ~m_axi4s;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // gain in 4.4 fixed point, then the offset, clamped to full scale
    function automatic video_pkg::comp_t expect_comp(input int unsigned v,
                                                     input lane_cfg_pkg::lane_cfg_t cfg);
        int unsigned scaled;
        scaled = ((32'(cfg.gain) * v) >> 4) + 32'(cfg.offset);
        if (scaled > 32'd255) begin
            return 8'hff;
        end
        return video_pkg::comp_t'(scaled);
    endfunction

    task automatic check_pixel(input video_pkg::pixel_t actual, input video_pkg::pixel_t expected);
        if (actual !== expected) begin
            $display("[ERROR] tdata: got %h, expected %h", actual, expected);
            mismatches++;
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            mismatches++;
        end
    endtask

    task automatic check_count(input video_pkg::coord_t actual, input video_pkg::coord_t expected,
                               input string name);
        if (actual !== expected) begin
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
            mismatches++;
        end
    endtask

    // the raster walk of one frame, blanking gives no beats
    task automatic push_frame(input int unsigned frame_no);
        video_pkg::beat_t b;
        for (int y = 0; y < `VID_HEIGHT; y++) begin
            for (int x = 0; x < `VID_WIDTH; x++) begin
                b.valid    = 1'b1;
                b.side.sof = (x == 0) && (y == 0);
                b.side.eol = (x == `VID_WIDTH - 1);
                b.pixel[0] = expect_comp(x, lane_cfg[0]);
                b.pixel[1] = expect_comp(y, lane_cfg[1]);
                b.pixel[2] = expect_comp(frame_no % 256, lane_cfg[2]);
                expected_q.push_back(b);
            end
        end
        rx_target = rx_target + video_pkg::coord_t'(BEATS_PER_FRAME);
    endtask

    // tready for the next rising edge is drawn here, so a valid beat seen
    // with tready high is the one that edge takes
    task automatic throttle_and_check_output();
        video_pkg::beat_t exp_beat;
        logic             ready;
        forever begin
            @(negedge m_axi4s);
            lcg_state = lcg_next(lcg_state);
            ready     = ((lcg_state >> 16) % 32'd100) >= busy_rate;
            tready    = ready;
            if (rst_n && tvalid && ready) begin
                rx_count++;
                if (expected_q.size() == 0) begin
                    $display("output beat arrived when no beat was expected");
                    other_errors++;
                end else begin
                    exp_beat = expected_q.pop_front();
                    check_pixel(tdata, exp_beat.pixel);
                    check_flag(tuser, exp_beat.side.sof, "tuser");
                    check_flag(tlast, exp_beat.side.eol, "tlast");
                end
            end
        end
    endtask

    task automatic wait_for_busy(input logic level);
        int cycles;
        cycles = 0;
        while (busy !== level && cycles < WAIT_LIMIT) begin
            @(negedge m_axi4s);
            cycles++;
        end
        if (busy !== level) begin
            $display("timed out waiting for busy to go to %0b", level);
            timeouts++;
            abort = 1'b1;
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
            @(negedge m_axi4s);
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("timed out waiting for the remaining output beats");
            timeouts++;
            abort = 1'b1;
        end
    endtask

    // one frame per enable pulse, so the count is exact
    task automatic run_case(input int n_frames);
        for (int f = 0; f < n_frames && !abort; f++) begin
            push_frame(32'(frames_run));
            enable = 1'b1;
            wait_for_busy(1'b1);
            enable = 1'b0;
            if (!abort) begin
                wait_for_busy(1'b0);
            end
            frames_run++;
        end
        if (!abort) begin
            wait_for_drain();
        end
        if (!abort) begin
            check_count(rx_count, rx_target, "beat count");
            check_count(frame, frames_run, "frame");
        end
    endtask

    initial begin : main
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  gains [3];
        logic [7:0]  offs [3];
        int          n_frames;
        int unsigned rate;
        rst_n        = 1'b0;
        enable       = 1'b0;
        lane_cfg     = '0;
        busy_rate    = 0;
        lcg_state    = 32'hb7879d15;
        rx_count     = '0;
        rx_target    = '0;
        frames_run   = '0;
        mismatches   = 0;
        timeouts     = 0;
        other_errors = 0;
        abort        = 1'b0;
        fork
            throttle_and_check_output();
        join_none
        repeat (8) @(posedge m_axi4s);
        @(negedge m_axi4s);
        rst_n = 1'b1;
        @(negedge m_axi4s);
        check_flag(busy, 1'b0, "busy");
        check_flag(tvalid, 1'b0, "tvalid");
        check_count(frame, '0, "frame");
        fd = $fopen("verif/video_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/video_stim.txt");
            other_errors++;
        end else begin
            while (!abort && $fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%h %h %h %h %h %h %d %d", gains[0], offs[0],
                                 gains[1], offs[1], gains[2], offs[2], n_frames, rate);
                if (fields != 8) begin
                    $display("malformed stimulus line: %s", line);
                    other_errors++;
                    continue;
                end
                for (int c = 0; c < `VID_COMPONENTS; c++) begin
                    lane_cfg[c] = '{gain: gains[c], offset: offs[c]};
                end
                busy_rate = rate;
                run_case(n_frames);
            end
            $fclose(fd);
        end
        $display("closing report: %0d mismatches, %0d timeouts, %0d other errors",
                 mismatches, timeouts, other_errors);
        if (mismatches + timeouts + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+hw
hw/video_pkg.sv
hw/lane_cfg_pkg.sv
hw/frame_source.sv
hw/component_lane.sv
hw/pixel_merge.sv
hw/video_pipe_top.sv
verif/video_pipe_assertions.sv
verif/video_pipe_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the video pipe testbench with Verilator, runs it and judges the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module video_pipe_tb -f list.f -o video_pipe_sim \
    && ./obj_dir/video_pipe_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation did not complete"; exit 1; }
cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/video_stim.txt ====
# columns: gain0 offset0 gain1 offset1 gain2 offset2 (hex), frames, tready busy percent (decimal)
# gains are unsigned 4.4 fixed point, so 10 is unity
10 00 10 00 10 00 2 0
18 05 0c 20 24 03 1 0
ff f0 80 f0 ff 10 1 0
ff ff ff ff ff ff 1 0
10 00 10 00 10 00 2 50
10 00 10 00 10 00 1 90
18 05 0c 20 24 03 1 50
ff f0 80 f0 ff 10 1 90
